//--- leaf_pkg.sv
`default_nettype none

package leaf_pkg;

    // ====================================================================
    // link and port geometry
    // ====================================================================
    localparam int PACKET_BITS   = 49;
    localparam int PAYLOAD_BITS  = 32;
    localparam int NUM_LEAF_BITS = 5;
    localparam int NUM_PORT_BITS = 4;
    localparam int NUM_ADDR_BITS = 7;
    localparam int NUM_IN_PORTS  = 6;
    localparam int NUM_OUT_PORTS = 2;
    localparam int CREDIT_BITS   = 6;
    localparam int CFG_PAD_BITS  = 23;

    localparam int FIFO_DEPTH    = 4;
    localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);

    localparam logic [NUM_LEAF_BITS-1:0] LEAF_ADDR = 5'd3;
    localparam logic [NUM_PORT_BITS-1:0] CFG_PORT  = 4'd0;   // config packets land here

    // ====================================================================
    // one link word, two decodings
    // ====================================================================
    typedef union packed {
        struct packed {
            logic                     valid;
            logic [NUM_LEAF_BITS-1:0] leaf;
            logic [NUM_PORT_BITS-1:0] port;
            logic [NUM_ADDR_BITS-1:0] addr;
            logic [PAYLOAD_BITS-1:0]  payload;
        } data;
        struct packed {
            logic                     valid;
            logic [NUM_LEAF_BITS-1:0] leaf;
            logic [NUM_PORT_BITS-1:0] port;
            logic                     cfg_out;      // 0 selects output 1
            logic [CREDIT_BITS-1:0]   cfg_credit;
            logic [CFG_PAD_BITS-1:0]  pad;
            logic [NUM_LEAF_BITS-1:0] dest_leaf;
            logic [NUM_PORT_BITS-1:0] dest_port;
        } cfg;
    } leaf_packet_t;

endpackage

`default_nettype wire

//--- port_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module port_fifo (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              wr_en,
    input  logic [leaf_pkg::PAYLOAD_BITS-1:0] wr_data,
    output logic                              full,
    input  logic                              rd_en,
    output logic [leaf_pkg::PAYLOAD_BITS-1:0] rd_data,
    output logic                              empty
);

    logic [leaf_pkg::PAYLOAD_BITS-1:0]  mem [leaf_pkg::FIFO_DEPTH];
    logic [leaf_pkg::FIFO_PTR_BITS-1:0] wr_ptr;
    logic [leaf_pkg::FIFO_PTR_BITS-1:0] rd_ptr;
    logic [leaf_pkg::FIFO_PTR_BITS:0]   count;
    logic                               do_wr;
    logic                               do_rd;

    assign full    = (int'(count) == leaf_pkg::FIFO_DEPTH);
    assign empty   = (count == '0);
    assign do_wr   = wr_en && (!full || rd_en);   // full write ok when a read frees a slot
    assign do_rd   = rd_en && !empty;
    assign rd_data = mem[rd_ptr];                 // head is always visible

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;          // wraps, depth is a power of two
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

endmodule

`default_nettype wire

//--- leaf_rx_unpack.sv
`timescale 1ns/10ps
`default_nettype none

module leaf_rx_unpack (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [leaf_pkg::PACKET_BITS-1:0]   din,
    output logic [leaf_pkg::PAYLOAD_BITS-1:0]  in_data_1, in_data_2, in_data_3,
    output logic [leaf_pkg::PAYLOAD_BITS-1:0]  in_data_4, in_data_5, in_data_6,
    output logic                               in_vld_1, in_vld_2, in_vld_3,
    output logic                               in_vld_4, in_vld_5, in_vld_6,
    input  logic                               in_ack_1, in_ack_2, in_ack_3,
    input  logic                               in_ack_4, in_ack_5, in_ack_6,
    output logic                               cfg_we,
    output logic                               cfg_out,
    output logic [leaf_pkg::CREDIT_BITS-1:0]   cfg_credit,
    output logic [leaf_pkg::NUM_LEAF_BITS-1:0] cfg_dest_leaf,
    output logic [leaf_pkg::NUM_PORT_BITS-1:0] cfg_dest_port
);

    leaf_pkg::leaf_packet_t             din_q;
    logic                               pkt_ok;
    logic [leaf_pkg::NUM_IN_PORTS-1:0]  fifo_wr;
    logic [leaf_pkg::NUM_IN_PORTS-1:0]  fifo_rd;
    logic [leaf_pkg::NUM_IN_PORTS-1:0]  fifo_empty;
    logic [leaf_pkg::PAYLOAD_BITS-1:0]  fifo_dout [leaf_pkg::NUM_IN_PORTS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            din_q <= '0;
        else
            din_q <= din;
    end

    // address filter, port 7 and up falls through
    assign pkt_ok = din_q.data.valid && (din_q.data.leaf == leaf_pkg::LEAF_ADDR) &&
                    (int'(din_q.data.port) <= leaf_pkg::NUM_IN_PORTS);

    // ====================================================================
    // configuration decode
    // ====================================================================
    assign cfg_we        = pkt_ok && (din_q.cfg.port == leaf_pkg::CFG_PORT);
    assign cfg_out       = din_q.cfg.cfg_out;
    assign cfg_credit    = din_q.cfg.cfg_credit;
    assign cfg_dest_leaf = din_q.cfg.dest_leaf;
    assign cfg_dest_port = din_q.cfg.dest_port;

    // ====================================================================
    // data unpack into the input FIFOs
    // ====================================================================
    for (genvar i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) begin : g_in
        assign fifo_wr[i] = pkt_ok && (int'(din_q.data.port) == i + 1);

        port_fifo u_fifo (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_en   (fifo_wr[i]),
            .wr_data (din_q.data.payload),
            .full    (),                  // overflow is dropped inside
            .rd_en   (fifo_rd[i]),
            .rd_data (fifo_dout[i]),
            .empty   (fifo_empty[i])
        );
    end

    assign fifo_rd = {in_ack_6, in_ack_5, in_ack_4, in_ack_3, in_ack_2, in_ack_1};

    assign in_data_1 = fifo_dout[0];
    assign in_data_2 = fifo_dout[1];
    assign in_data_3 = fifo_dout[2];
    assign in_data_4 = fifo_dout[3];
    assign in_data_5 = fifo_dout[4];
    assign in_data_6 = fifo_dout[5];

    assign {in_vld_6, in_vld_5, in_vld_4, in_vld_3, in_vld_2, in_vld_1} = ~fifo_empty;

endmodule

`default_nettype wire

//--- user_kernel.sv
`timescale 1ns/10ps
`default_nettype none

module user_kernel (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [leaf_pkg::PAYLOAD_BITS-1:0] in_data_1, in_data_2, in_data_3,
    input  logic [leaf_pkg::PAYLOAD_BITS-1:0] in_data_4, in_data_5, in_data_6,
    input  logic                              in_vld_1, in_vld_2, in_vld_3,
    input  logic                              in_vld_4, in_vld_5, in_vld_6,
    output logic                              in_ack_1, in_ack_2, in_ack_3,
    output logic                              in_ack_4, in_ack_5, in_ack_6,
    output logic [leaf_pkg::PAYLOAD_BITS-1:0] out_data_1, out_data_2,
    output logic                              out_vld_1, out_vld_2,
    input  logic                              out_ack_1, out_ack_2
);

    logic [leaf_pkg::PAYLOAD_BITS-1:0]  in_data [leaf_pkg::NUM_IN_PORTS];
    logic [leaf_pkg::NUM_IN_PORTS-1:0]  in_vld;
    logic [leaf_pkg::NUM_IN_PORTS-1:0]  in_ack;
    logic [leaf_pkg::PAYLOAD_BITS-1:0]  res_data [leaf_pkg::NUM_OUT_PORTS];
    logic [leaf_pkg::NUM_OUT_PORTS-1:0] res_vld;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0] out_ack;

    assign in_data = '{in_data_1, in_data_2, in_data_3, in_data_4, in_data_5, in_data_6};
    assign in_vld  = {in_vld_6, in_vld_5, in_vld_4, in_vld_3, in_vld_2, in_vld_1};
    assign out_ack = {out_ack_2, out_ack_1};

    assign {in_ack_6, in_ack_5, in_ack_4, in_ack_3, in_ack_2, in_ack_1} = in_ack;

    // lane g adds ports 3g+1 .. 3g+3
    for (genvar g = 0; g < leaf_pkg::NUM_OUT_PORTS; g++) begin : g_lane
        logic                              fire;
        logic                              vld_q;
        logic [leaf_pkg::PAYLOAD_BITS-1:0] sum_q;

        assign fire = (&in_vld[3*g +: 3]) && (!vld_q || out_ack[g]);
        assign in_ack[3*g +: 3] = {3{fire}};    // all three taken together

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n)
                vld_q <= 1'b0;
            else if (fire)
                vld_q <= 1'b1;
            else if (out_ack[g])
                vld_q <= 1'b0;
        end

        always_ff @(posedge clk) begin
            if (fire)
                sum_q <= in_data[3*g] + in_data[3*g+1] + in_data[3*g+2];   // wraps
        end

        assign res_data[g] = sum_q;
        assign res_vld[g]  = vld_q;
    end

    assign out_data_1 = res_data[0];
    assign out_data_2 = res_data[1];
    assign out_vld_1  = res_vld[0];
    assign out_vld_2  = res_vld[1];

endmodule

`default_nettype wire

//--- leaf_tx_pack.sv
`timescale 1ns/10ps
`default_nettype none

module leaf_tx_pack (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [leaf_pkg::PAYLOAD_BITS-1:0]  out_data_1, out_data_2,
    input  logic                               out_vld_1, out_vld_2,
    output logic                               out_ack_1, out_ack_2,
    input  logic                               cfg_we,
    input  logic                               cfg_out,
    input  logic [leaf_pkg::CREDIT_BITS-1:0]   cfg_credit,
    input  logic [leaf_pkg::NUM_LEAF_BITS-1:0] cfg_dest_leaf,
    input  logic [leaf_pkg::NUM_PORT_BITS-1:0] cfg_dest_port,
    input  logic                               resend,
    output logic [leaf_pkg::PACKET_BITS-1:0]   dout
);

    logic [leaf_pkg::PAYLOAD_BITS-1:0]  out_data [leaf_pkg::NUM_OUT_PORTS];
    logic [leaf_pkg::NUM_OUT_PORTS-1:0] out_vld;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0] fifo_full;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0] fifo_empty;
    logic [leaf_pkg::PAYLOAD_BITS-1:0]  fifo_dout [leaf_pkg::NUM_OUT_PORTS];
    logic [leaf_pkg::CREDIT_BITS-1:0]   credit [leaf_pkg::NUM_OUT_PORTS];
    logic [leaf_pkg::NUM_LEAF_BITS-1:0] dest_leaf [leaf_pkg::NUM_OUT_PORTS];
    logic [leaf_pkg::NUM_PORT_BITS-1:0] dest_port [leaf_pkg::NUM_OUT_PORTS];
    logic [leaf_pkg::NUM_ADDR_BITS-1:0] seq [leaf_pkg::NUM_OUT_PORTS];
    logic [leaf_pkg::NUM_OUT_PORTS-1:0] elig;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0] take;
    logic                               grant;
    logic                               sel;
    logic                               prio;        // set when output 2 goes first
    leaf_pkg::leaf_packet_t             tx_pkt;
    logic [leaf_pkg::PACKET_BITS-1:0]   dout_q;

    assign out_data = '{out_data_1, out_data_2};
    assign out_vld  = {out_vld_2, out_vld_1};
    assign out_ack_1 = !fifo_full[0];
    assign out_ack_2 = !fifo_full[1];

    // ====================================================================
    // per-output FIFO, credits, destination and sequence
    // ====================================================================
    for (genvar i = 0; i < leaf_pkg::NUM_OUT_PORTS; i++) begin : g_out
        logic                           cfg_hit;
        logic [leaf_pkg::CREDIT_BITS:0] credit_nxt;

        port_fifo u_fifo (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_en   (out_vld[i] && !fifo_full[i]),
            .wr_data (out_data[i]),
            .full    (fifo_full[i]),
            .rd_en   (take[i]),
            .rd_data (fifo_dout[i]),
            .empty   (fifo_empty[i])
        );

        assign cfg_hit    = cfg_we && (int'(cfg_out) == i);
        assign credit_nxt = {1'b0, credit[i]} + (cfg_hit ? {1'b0, cfg_credit} : '0)
                          - {{leaf_pkg::CREDIT_BITS{1'b0}}, take[i]};
        assign elig[i]    = !fifo_empty[i] && (credit[i] != '0) && !resend;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                credit[i]    <= '0;
                dest_leaf[i] <= '0;
                dest_port[i] <= '0;
                seq[i]       <= '0;
            end else begin
                credit[i] <= credit_nxt[leaf_pkg::CREDIT_BITS] ? '1 :
                             credit_nxt[leaf_pkg::CREDIT_BITS-1:0];   // saturate at 63
                if (cfg_hit) begin
                    dest_leaf[i] <= cfg_dest_leaf;
                    dest_port[i] <= cfg_dest_port;
                end
                if (take[i])
                    seq[i] <= seq[i] + 1'b1;
            end
        end
    end

    // ====================================================================
    // round-robin pick and packet build
    // ====================================================================
    assign grant = |elig;
    assign sel   = !(elig[0] && (!prio || !elig[1]));
    assign take  = grant ? (sel ? 2'b10 : 2'b01) : 2'b00;

    always_comb begin
        tx_pkt              = '0;
        tx_pkt.data.valid   = 1'b1;
        tx_pkt.data.leaf    = dest_leaf[sel];
        tx_pkt.data.port    = dest_port[sel];
        tx_pkt.data.addr    = seq[sel];
        tx_pkt.data.payload = fifo_dout[sel];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio   <= 1'b0;
            dout_q <= '0;
        end else if (!resend) begin              // a packet caught by resend is kept
            if (grant)
                prio <= !sel;
            dout_q <= grant ? tx_pkt : '0;
        end
    end

    assign dout = resend ? '0 : dout_q;

endmodule

`default_nettype wire

//--- leaf_i6o2.sv
`timescale 1ns/10ps
`default_nettype none

module leaf_i6o2 (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [leaf_pkg::PACKET_BITS-1:0] din,
    output logic [leaf_pkg::PACKET_BITS-1:0] dout,
    input  logic                             resend
);

    // ====================================================================
    // input side to kernel
    // ====================================================================
    logic [leaf_pkg::PAYLOAD_BITS-1:0]  in_data_1, in_data_2, in_data_3;
    logic [leaf_pkg::PAYLOAD_BITS-1:0]  in_data_4, in_data_5, in_data_6;
    logic                               in_vld_1, in_vld_2, in_vld_3;
    logic                               in_vld_4, in_vld_5, in_vld_6;
    logic                               in_ack_1, in_ack_2, in_ack_3;
    logic                               in_ack_4, in_ack_5, in_ack_6;

    // kernel to output side
    logic [leaf_pkg::PAYLOAD_BITS-1:0]  out_data_1, out_data_2;
    logic                               out_vld_1, out_vld_2;
    logic                               out_ack_1, out_ack_2;

    // config path
    logic                               cfg_we;
    logic                               cfg_out;
    logic [leaf_pkg::CREDIT_BITS-1:0]   cfg_credit;
    logic [leaf_pkg::NUM_LEAF_BITS-1:0] cfg_dest_leaf;
    logic [leaf_pkg::NUM_PORT_BITS-1:0] cfg_dest_port;

    // all nets share port names
    leaf_rx_unpack u_rx (
        .*
    );

    user_kernel u_kernel (
        .*
    );

    leaf_tx_pack u_tx (
        .*
    );

endmodule

`default_nettype wire

//--- tb_leaf_i6o2.sv
`timescale 1ns/10ps
`default_nettype none

module tb_leaf_i6o2;

    localparam int WAIT_LIMIT = 200;

    logic                             clk;
    logic                             rst_n;
    logic [leaf_pkg::PACKET_BITS-1:0] din;
    logic [leaf_pkg::PACKET_BITS-1:0] dout;
    logic                             resend;

    logic [leaf_pkg::PACKET_BITS-1:0] seen [$];   // valid dout packets not yet matched
    logic [7:0]                       lfsr;

    leaf_i6o2 dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .din    (din),
        .dout   (dout),
        .resend (resend)
    );

    always #2 clk = ~clk;

    // dout is stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && dout[leaf_pkg::PACKET_BITS-1])
            seen.push_back(dout);
    end

    // ==================================================================
    // checking
    // ==================================================================
    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name,
                               input logic [leaf_pkg::PACKET_BITS-1:0] expected,
                               input logic [leaf_pkg::PACKET_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h got %h", name, expected, actual);
            abort_run();
        end
    endtask

    // ==================================================================
    // random idle gaps
    // ==================================================================
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        lfsr_next = state[0] ? ((state >> 1) ^ 8'hb8) : (state >> 1);
    endfunction

    task automatic take_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    task automatic idle_gap();
        logic b0;
        logic b1;
        take_bit(b0);
        take_bit(b1);
        repeat ({b1, b0}) @(posedge clk);         // 0 to 3 cycles
    endtask

    // ==================================================================
    // link driving and output waits
    // ==================================================================
    task automatic send_packet(input logic [leaf_pkg::PACKET_BITS-1:0] pkt);
        @(posedge clk);
        din <= pkt;
        @(posedge clk);
        din <= '0;
        idle_gap();
    endtask

    task automatic drive_resend(input logic level);
        @(posedge clk);
        resend <= level;
    endtask

    task automatic expect_packet(input logic [leaf_pkg::PACKET_BITS-1:0] pkt);
        int n;
        n = 0;
        while (seen.size() == 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (seen.size() == 0) begin
            $display("no output packet before timeout");
            abort_run();
        end
        check_value("dout", pkt, seen.pop_front());
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("dout", '0, dout);
        end
    endtask

    initial begin
        int                               fd;
        int                               rc;
        int                               n;
        string                            line;
        logic [7:0]                       op;
        logic [31:0]                      v;
        logic [31:0]                      leaf;
        logic [31:0]                      port;
        logic [31:0]                      addr;
        logic [31:0]                      payload;
        logic [leaf_pkg::PACKET_BITS-1:0] pkt;

        clk    = 1'b0;
        rst_n  = 1'b0;
        din    = '0;
        resend = 1'b0;
        lfsr   = 8'd21;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        fd = $fopen("leaf_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open leaf_tests.txt");
            abort_run();
        end

        while (!$feof(fd)) begin
            line = "";
            rc   = $fgets(line, fd);
            n    = $sscanf(line, "%c %h %h %h %h %h", op, v, leaf, port, addr, payload);
            if (rc != 0 && n >= 1 && op != "#" && op != 8'h0a) begin
                pkt = {v[0], leaf[4:0], port[3:0], addr[6:0], payload};
                case (op)
                    "S": send_packet(pkt);
                    "R": drive_resend(v[0]);
                    "W": expect_packet(pkt);
                    "Q": expect_quiet(int'(v));
                    default: begin
                        $display("unknown opcode in leaf_tests.txt");
                        abort_run();
                    end
                endcase
            end
        end
        $fclose(fd);

        if (seen.size() != 0) begin
            $display("an output packet arrived that no W line expected");
            abort_run();
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- leaf_tests.txt
# op S send din, W expect dout, R resend level, Q dout quiet for n cycles (all fields hex)
# S and W fields: valid leaf port addr payload; config uses addr={out,credit} payload={dleaf,dport}
S 1 03 1 00 00000011
S 1 03 2 00 00000022
S 1 03 3 00 00000033
Q 14
S 1 03 0 02 00000052
W 1 05 2 00 00000066
S 1 03 1 00 00000100
S 1 03 2 00 00000200
S 1 03 3 00 00000300
W 1 05 2 01 00000600
S 1 03 1 00 00001000
S 1 03 2 00 00002000
S 1 03 3 00 00003000
Q 14
S 1 03 0 01 00000052
W 1 05 2 02 00006000
S 1 03 0 04 00000052
S 1 03 0 45 000000a4
S 1 03 1 00 ffffffff
S 1 03 2 00 00000002
S 1 03 3 00 00000003
S 1 03 4 00 00000010
S 1 03 5 00 00000020
S 1 03 6 00 00000030
S 1 03 1 00 01010101
S 1 03 2 00 02020202
S 1 03 3 00 03030303
S 1 03 4 00 80000000
S 1 03 5 00 80000000
S 1 03 6 00 00000007
W 1 05 2 03 00000004
W 1 0a 4 00 00000060
W 1 05 2 04 06060606
W 1 0a 4 01 00000007
S 1 04 4 00 deadbeef
S 1 03 7 00 deadbeef
S 1 03 f 00 deadbeef
S 0 03 5 00 deadbeef
Q 0a
S 1 03 4 00 00000001
S 1 03 5 00 00000002
S 1 03 6 00 00000003
W 1 0a 4 02 00000006
R 1
S 1 03 1 00 0000000a
S 1 03 2 00 0000000b
S 1 03 3 00 0000000c
S 1 03 4 00 00001000
S 1 03 5 00 00001000
S 1 03 6 00 00001000
Q 0a
R 0
W 1 05 2 05 00000021
W 1 0a 4 03 00003000
Q 0a

//--- list.f
leaf_pkg.sv
port_fifo.sv
leaf_rx_unpack.sv
user_kernel.sv
leaf_tx_pack.sv
leaf_i6o2.sv
tb_leaf_i6o2.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module tb_leaf_i6o2 -f list.f

# pass only when the pass line shows up in the simulator output
run: compile
	@out="$$(./obj_dir/Vtb_leaf_i6o2 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
